/* verilog/bj_card_pkg.sv */
// card ranks are 1..13 with 0 meaning no card, totals assume at most 9 cards per hand
package bj_card_pkg;

    // ------------------------------
    // types
    // ------------------------------
    typedef logic [3:0] rank_t;   // 1 ace .. 13 king, 0 is empty
    typedef logic [4:0] score_t;  // hand total, reaches 31 at most
    typedef logic [3:0] count_t;  // cards held, 0..9

    // ------------------------------
    // hand rules
    // ------------------------------
    localparam int HAND_SIZE  = 9;   // max cards per hand
    localparam int BUST_LIMIT = 21;
    localparam int ACE_BONUS  = 10;  // one ace counted as 11
    localparam int FACE_VALUE = 10;  // jack, queen and king

    // valid rank window for the card source
    localparam int RANK_MIN = 1;
    localparam int RANK_MAX = 13;

    // lfsr start value, any nonzero seed works
    localparam logic [15:0] LFSR_SEED = 16'hace1;

endpackage

/* verilog/bj_game_pkg.sv */
// game level encodings only, phase and result values are visible at the top level ports
package bj_game_pkg;

    // controller states
    typedef enum logic [3:0] {
        ST_IDLE,
        ST_READY,
        ST_DEAL_DRAW,
        ST_DEAL_WAIT,
        ST_PLAYER_TURN,
        ST_PLAYER_DRAW,
        ST_PLAYER_CHECK,
        ST_DEALER_DRAW,
        ST_DEALER_CHECK,
        ST_COMPARE,
        ST_DONE
    } game_state_t;

    // phase seen from outside
    typedef enum logic [2:0] {
        PH_IDLE,
        PH_READY,
        PH_DEALING,
        PH_PLAYER_TURN,
        PH_DEALER_TURN,
        PH_DONE
    } phase_t;

    typedef enum logic [1:0] {
        RES_NONE,
        RES_PLAYER_WIN,
        RES_DEALER_WIN,
        RES_PUSH
    } result_t;

    localparam int DEALER_STAND  = 17;  // dealer draws below this
    localparam int INITIAL_CARDS = 3;   // player, dealer, player
endpackage

/* verilog/hand_if.sv */
// totals and counts show a write one cycle after wr, clr empties both hands on the next edge
`timescale 1ns/10ps

interface hand_if;
    import bj_card_pkg::*;

    // ------------------------------
    // controller side
    // ------------------------------
    logic   clr;        // empty both hands
    logic   wr;         // one cycle append
    logic   to_dealer;  // target hand of wr
    rank_t  card;

    // ------------------------------
    // ledger side
    // ------------------------------
    score_t player_total;  // best totals, soft aces resolved
    score_t dealer_total;
    count_t player_count;
    count_t dealer_count;

    modport ctrl (
        output clr, wr, to_dealer, card,
        input  player_total, dealer_total, player_count, dealer_count
    );

    modport ledger (
        input  clr, wr, to_dealer, card,
        output player_total, dealer_total, player_count, dealer_count
    );

endinterface

/* verilog/card_source.sv */
// four-phase handshake, card_rank is valid while card_ack is high and ack waits for req to fall
`timescale 1ns/10ps

module card_source (
    input  logic               clk,
    input  logic               rst,
    input  logic               card_req,
    output logic               card_ack,
    output bj_card_pkg::rank_t card_rank
);
    import bj_card_pkg::*;

    logic [15:0] lfsr;
    logic        feedback;
    rank_t       candidate;
    logic        rank_ok;
    logic        take;

    // ------------------------------
    // free running lfsr
    // ------------------------------
    // x^16 + x^14 + x^13 + x^11 + 1, maximal length
    assign feedback = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];

    always_ff @(posedge clk) begin
        if (rst) begin
            lfsr <= LFSR_SEED;
        end else begin
            lfsr <= {lfsr[14:0], feedback};
        end
    end

    // ------------------------------
    // rank rejection
    // ------------------------------
    assign candidate = lfsr[3:0];
    assign rank_ok   = (candidate >= rank_t'(RANK_MIN)) && (candidate <= rank_t'(RANK_MAX));

    // accept only on an open request with ack still low
    assign take = card_req && !card_ack && rank_ok;

    always_ff @(posedge clk) begin
        if (rst) begin
            card_ack <= 1'b0;
        end else if (!card_req) begin
            card_ack <= 1'b0;  // req dropped, close handshake
        end else if (take) begin
            card_ack <= 1'b1;
        end
    end

    // rank held until the next accepted value
    always_ff @(posedge clk) begin
        if (take) begin
            card_rank <= candidate;
        end
    end

endmodule

/* verilog/hand_ledger.sv */
// writes to a full hand are dropped, totals count an ace as 11 only while that stays within 21
`timescale 1ns/10ps

module hand_ledger (
    input logic  clk,
    input logic  rst,
    hand_if.ledger hand
);
    import bj_card_pkg::*;

    // index 0 is the player, 1 the dealer
    rank_t  cards [2][HAND_SIZE];
    count_t count [2];
    score_t hard  [2];  // aces as 1, faces as 10
    logic   ace   [2];
    score_t best  [2];
    logic   room;       // target hand not full

    function automatic score_t card_value(input rank_t rank);
        score_t value;
        if (rank > rank_t'(FACE_VALUE)) begin
            value = score_t'(FACE_VALUE);
        end else begin
            value = score_t'(rank);
        end
        return value;
    endfunction

    assign room = count[hand.to_dealer] < count_t'(HAND_SIZE);

    // ------------------------------
    // card counts
    // ------------------------------
    always_ff @(posedge clk) begin
        if (rst || hand.clr) begin
            count[0] <= '0;
            count[1] <= '0;
        end else if (hand.wr && room) begin
            count[hand.to_dealer] <= count[hand.to_dealer] + count_t'(1);
        end
    end

    // slots at or above count are ignored, so no clear needed
    always_ff @(posedge clk) begin
        if (hand.wr && room && !hand.clr) begin
            cards[hand.to_dealer][count[hand.to_dealer]] <= hand.card;
        end
    end

    // ------------------------------
    // totals
    // ------------------------------
    always_comb begin
        for (int h = 0; h < 2; h++) begin
            hard[h] = '0;
            ace[h]  = 1'b0;
            for (int i = 0; i < HAND_SIZE; i++) begin
                if (count_t'(i) < count[h]) begin
                    hard[h] = hard[h] + card_value(cards[h][i]);
                    ace[h]  = ace[h] | (cards[h][i] == rank_t'(1));
                end
            end
            // one soft ace at most can fit under 21
            if (ace[h] && (hard[h] <= score_t'(BUST_LIMIT - ACE_BONUS))) begin
                best[h] = hard[h] + score_t'(ACE_BONUS);
            end else begin
                best[h] = hard[h];
            end
        end
    end

    assign hand.player_total = best[0];
    assign hand.dealer_total = best[1];
    assign hand.player_count = count[0];
    assign hand.dealer_count = count[1];

endmodule

/* verilog/blackjack_fsm.sv */
// buttons are one-cycle pulses, result holds until the next start and totals are read a cycle after wr
`timescale 1ns/10ps

module blackjack_fsm (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  start,
    input  logic                  deal,
    input  logic                  hit,
    input  logic                  stand,
    output logic                  card_req,
    input  logic                  card_ack,
    input  bj_card_pkg::rank_t    card_rank,
    hand_if.ctrl                  hand,
    output bj_game_pkg::phase_t   phase,
    output bj_game_pkg::result_t  result
);
    import bj_card_pkg::*;
    import bj_game_pkg::*;

    game_state_t state, state_nxt;
    result_t     result_nxt;
    logic [1:0]  deal_idx, deal_idx_nxt;  // position in the opening deal
    logic        clr_nxt;
    logic        drawing;
    logic        draw_done;

    function automatic phase_t phase_of(input game_state_t st);
        phase_t ph;
        case (st)
            ST_READY:                               ph = PH_READY;
            ST_DEAL_DRAW, ST_DEAL_WAIT:             ph = PH_DEALING;
            ST_PLAYER_TURN, ST_PLAYER_DRAW,
            ST_PLAYER_CHECK:                        ph = PH_PLAYER_TURN;
            ST_DEALER_DRAW, ST_DEALER_CHECK,
            ST_COMPARE:                             ph = PH_DEALER_TURN;
            ST_DONE:                                ph = PH_DONE;
            default:                                ph = PH_IDLE;
        endcase
        return ph;
    endfunction

    assign drawing   = (state == ST_DEAL_DRAW) || (state == ST_PLAYER_DRAW)
                    || (state == ST_DEALER_DRAW);
    assign card_req  = drawing;              // falls the cycle after ack
    assign draw_done = drawing && card_ack;

    // ------------------------------
    // next state
    // ------------------------------
    always_comb begin
        state_nxt    = state;
        result_nxt   = result;
        deal_idx_nxt = deal_idx;
        clr_nxt      = 1'b0;
        case (state)
            ST_IDLE, ST_DONE: begin
                if (start) begin
                    state_nxt  = ST_READY;
                    result_nxt = RES_NONE;
                    clr_nxt    = 1'b1;
                end
            end
            ST_READY: begin
                if (deal) begin
                    state_nxt    = ST_DEAL_DRAW;
                    deal_idx_nxt = '0;
                end
            end
            ST_DEAL_DRAW:   if (card_ack) state_nxt = ST_DEAL_WAIT;
            ST_DEAL_WAIT: begin  // card written this cycle
                if (deal_idx == 2'(INITIAL_CARDS - 1)) begin
                    state_nxt = ST_PLAYER_TURN;
                end else begin
                    state_nxt    = ST_DEAL_DRAW;
                    deal_idx_nxt = deal_idx + 2'd1;
                end
            end
            ST_PLAYER_TURN: begin
                if (hit && (hand.player_count < count_t'(HAND_SIZE))) begin
                    state_nxt = ST_PLAYER_DRAW;  // full hand ignores hit
                end else if (stand) begin
                    state_nxt = ST_DEALER_CHECK;
                end
            end
            ST_PLAYER_DRAW: if (card_ack) state_nxt = ST_PLAYER_CHECK;
            ST_PLAYER_CHECK: begin
                if (!hand.wr) begin  // let the ledger settle
                    if (hand.player_total > score_t'(BUST_LIMIT)) begin
                        state_nxt  = ST_DONE;
                        result_nxt = RES_DEALER_WIN;
                    end else begin
                        state_nxt = ST_PLAYER_TURN;
                    end
                end
            end
            ST_DEALER_DRAW: if (card_ack) state_nxt = ST_DEALER_CHECK;
            ST_DEALER_CHECK: begin
                if (!hand.wr) begin
                    if (hand.dealer_total > score_t'(BUST_LIMIT)) begin
                        state_nxt  = ST_DONE;
                        result_nxt = RES_PLAYER_WIN;
                    end else if ((hand.dealer_total < score_t'(DEALER_STAND))
                              && (hand.dealer_count < count_t'(HAND_SIZE))) begin
                        state_nxt = ST_DEALER_DRAW;
                    end else begin
                        state_nxt = ST_COMPARE;
                    end
                end
            end
            ST_COMPARE: begin
                state_nxt = ST_DONE;
                if (hand.player_total > hand.dealer_total) begin
                    result_nxt = RES_PLAYER_WIN;
                end else if (hand.player_total < hand.dealer_total) begin
                    result_nxt = RES_DEALER_WIN;
                end else begin
                    result_nxt = RES_PUSH;
                end
            end
            default:        state_nxt = ST_IDLE;
        endcase
    end

    // ------------------------------
    // registers
    // ------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= ST_IDLE;
            deal_idx <= '0;
            result   <= RES_NONE;
            phase    <= PH_IDLE;
            hand.clr <= 1'b0;
            hand.wr  <= 1'b0;
        end else begin
            state    <= state_nxt;
            deal_idx <= deal_idx_nxt;
            result   <= result_nxt;
            phase    <= phase_of(state_nxt);  // moves with result
            hand.clr <= clr_nxt;
            hand.wr  <= draw_done;            // strobe one cycle after ack
        end
    end

    // card payload to the ledger
    always_ff @(posedge clk) begin
        if (draw_done) begin
            hand.card      <= card_rank;
            // opening deal alternates on the low index bit
            hand.to_dealer <= (state == ST_DEALER_DRAW)
                           || ((state == ST_DEAL_DRAW) && deal_idx[0]);
        end
    end

endmodule

/* verilog/blackjack_top.sv */
// one player against the dealer, buttons are one-cycle pulses, card_rank is valid with card_strobe
`timescale 1ns/10ps

module blackjack_top (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start,
    input  logic                 deal,
    input  logic                 hit,
    input  logic                 stand,
    output bj_game_pkg::phase_t  phase,
    output bj_game_pkg::result_t result,
    output bj_card_pkg::score_t  player_total,
    output bj_card_pkg::score_t  dealer_total,
    output logic                 card_strobe,
    output bj_card_pkg::rank_t   card_rank,
    output logic                 card_to_dealer
);
    import bj_card_pkg::*;

    logic  card_req;
    logic  card_ack;
    rank_t src_rank;  // straight from the source

    hand_if hand ();

    blackjack_fsm u_fsm (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .deal      (deal),
        .hit       (hit),
        .stand     (stand),
        .card_req  (card_req),
        .card_ack  (card_ack),
        .card_rank (src_rank),
        .hand      (hand.ctrl),
        .phase     (phase),
        .result    (result)
    );

    card_source u_source (
        .clk       (clk),
        .rst       (rst),
        .card_req  (card_req),
        .card_ack  (card_ack),
        .card_rank (src_rank)
    );

    hand_ledger u_ledger (
        .clk  (clk),
        .rst  (rst),
        .hand (hand.ledger)
    );

    // every dealt card shows up on the write strobe
    assign card_strobe    = hand.wr;
    assign card_rank      = hand.card;
    assign card_to_dealer = hand.to_dealer;
    assign player_total   = hand.player_total;
    assign dealer_total   = hand.dealer_total;

endmodule

/* dv/blackjack_tb.sv */
// plays 40 seeded games through the top level ports, stops at the first error, no file or wave output
`timescale 1ns/10ps

module blackjack_tb;
    import bj_card_pkg::*;
    import bj_game_pkg::*;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 16;
    localparam int NUM_GAMES    = 40;
    localparam int GAME_CYCLES  = 2000;  // upper bound for one game
    localparam int WAIT_LIMIT   = 500;   // one handshake or phase wait
    localparam int BTN_START    = 0;
    localparam int BTN_DEAL     = 1;
    localparam int BTN_HIT      = 2;
    localparam int BTN_STAND    = 3;

    logic        clk;
    logic        rst;
    logic        start;
    logic        deal;
    logic        hit;
    logic        stand;
    phase_t      phase;
    result_t     result;
    score_t      player_total;
    score_t      dealer_total;
    logic        card_strobe;
    rank_t       card_rank;
    logic        card_to_dealer;

    // reference hands, 0 player and 1 dealer
    int          model_count [2];
    int          model_hard  [2];
    bit          model_ace   [2];
    int          strobe_count;
    int          dest_log [$];  // target of each card since start
    bit          totals_due;
    int unsigned lcg_state = 32'd57586;

    blackjack_top dut_i (
        .clk            (clk),
        .rst            (rst),
        .start          (start),
        .deal           (deal),
        .hit            (hit),
        .stand          (stand),
        .phase          (phase),
        .result         (result),
        .player_total   (player_total),
        .dealer_total   (dealer_total),
        .card_strobe    (card_strobe),
        .card_rank      (card_rank),
        .card_to_dealer (card_to_dealer)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ------------------------------
    // helpers
    // ------------------------------
    task automatic report_failure(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic check_equal(input string name, input int got, input int exp);
        if (got != exp) begin
            report_failure($sformatf("Mismatch at %0t: %s got %0d, expected %0d",
                                     $time, name, got, exp));
        end
    endtask

    function automatic int next_random(input int unsigned n);
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return int'((lcg_state >> 16) % n);
    endfunction

    function automatic int card_points(input int rank);
        if (rank > FACE_VALUE) begin
            return FACE_VALUE;  // jack, queen, king
        end
        return rank;
    endfunction

    // one ace may count 11 while the hand stays at 21 or less
    function automatic int best_total(input int h);
        if (model_ace[h] && (model_hard[h] + ACE_BONUS <= BUST_LIMIT)) begin
            return model_hard[h] + ACE_BONUS;
        end
        return model_hard[h];
    endfunction

    task automatic clear_model();
        for (int h = 0; h < 2; h++) begin
            model_count[h] = 0;
            model_hard[h]  = 0;
            model_ace[h]   = 1'b0;
        end
        dest_log.delete();
    endtask

    task automatic press(input int button);
        @(posedge clk);
        #2;
        case (button)
            BTN_START: start = 1'b1;
            BTN_DEAL:  deal  = 1'b1;
            BTN_HIT:   hit   = 1'b1;
            default:   stand = 1'b1;
        endcase
        @(posedge clk);
        #2;
        start = 1'b0;
        deal  = 1'b0;
        hit   = 1'b0;
        stand = 1'b0;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    task automatic wait_strobes(input int target);
        int cycles;
        cycles = 0;
        while (strobe_count < target) begin
            @(posedge clk);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                report_failure("no card strobe arrived within the wait limit");
            end
        end
    endtask

    task automatic wait_phase(input phase_t target);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (phase != target) begin
            @(negedge clk);
            cycles++;
            if (cycles > GAME_CYCLES) begin
                report_failure($sformatf("phase never reached %0d", int'(target)));
            end
        end
    endtask

    // ------------------------------
    // card monitor and model
    // ------------------------------
    always @(negedge clk) begin : card_monitor
        int h;
        int r;
        if (!rst) begin
            if (totals_due) begin  // ledger settles one cycle after the strobe
                check_equal("player_total", int'(player_total), best_total(0));
                check_equal("dealer_total", int'(dealer_total), best_total(1));
                totals_due = 1'b0;
            end
            if (card_strobe) begin
                h = int'(card_to_dealer);
                r = int'(card_rank);
                if (r < 1 || r > 13) begin
                    report_failure($sformatf("card rank %0d is outside 1 to 13", r));
                end
                if (phase == PH_PLAYER_TURN && h != 0) begin
                    report_failure("dealer card dealt during the player turn");
                end
                if (phase == PH_DEALER_TURN) begin
                    if (h != 1) begin
                        report_failure("player card dealt during the dealer turn");
                    end
                    if (best_total(1) >= DEALER_STAND || model_count[1] >= HAND_SIZE) begin
                        report_failure("dealer drew a card past its stand rule");
                    end
                end
                if (model_count[h] >= HAND_SIZE) begin
                    report_failure("card dealt to a full hand");
                end
                model_count[h]++;
                model_hard[h] += card_points(r);
                if (r == 1) begin
                    model_ace[h] = 1'b1;
                end
                dest_log.push_back(h);
                strobe_count++;
                totals_due = 1'b1;
            end
        end
    end

    // ------------------------------
    // one game
    // ------------------------------
    task automatic play_game();
        int      hits;
        int      base;
        int      p;
        int      d;
        result_t expect_res;
        hits = next_random(HAND_SIZE);  // up to one hit past a full hand
        idle_cycles(next_random(4));
        press(BTN_START);
        wait_phase(PH_READY);
        clear_model();
        check_equal("result", int'(result), int'(RES_NONE));
        @(negedge clk);  // clr lands one edge later
        check_equal("player_total", int'(player_total), 0);
        check_equal("dealer_total", int'(dealer_total), 0);

        // hit or stand before the deal is ignored
        base = strobe_count;
        press(next_random(2) == 0 ? BTN_HIT : BTN_STAND);
        idle_cycles(4);
        @(negedge clk);
        check_equal("phase", int'(phase), int'(PH_READY));
        check_equal("strobe count", strobe_count, base);

        idle_cycles(next_random(4));
        press(BTN_DEAL);
        wait_strobes(base + INITIAL_CARDS);
        wait_phase(PH_PLAYER_TURN);
        check_equal("strobe count", strobe_count, base + INITIAL_CARDS);
        check_equal("card_to_dealer card 1", dest_log[0], 0);
        check_equal("card_to_dealer card 2", dest_log[1], 1);
        check_equal("card_to_dealer card 3", dest_log[2], 0);

        if (next_random(3) == 0) begin  // start mid game
            press(BTN_START);
            idle_cycles(3);
            @(negedge clk);
            check_equal("phase", int'(phase), int'(PH_PLAYER_TURN));
            check_equal("result", int'(result), int'(RES_NONE));
            check_equal("strobe count", strobe_count, base + INITIAL_CARDS);
        end

        expect_res = RES_DEALER_WIN;
        for (int i = 0; i < hits; i++) begin
            base = strobe_count;
            idle_cycles(next_random(5));
            press(BTN_HIT);
            if (model_count[0] >= HAND_SIZE) begin
                idle_cycles(6);
                @(negedge clk);
                check_equal("strobe count", strobe_count, base);
                check_equal("phase", int'(phase), int'(PH_PLAYER_TURN));
            end else begin
                wait_strobes(base + 1);
                @(posedge clk);  // check cycle, then the decision edge
                @(negedge clk);
                if (best_total(0) > BUST_LIMIT) begin
                    check_equal("phase", int'(phase), int'(PH_DONE));
                    check_equal("result", int'(result), int'(RES_DEALER_WIN));
                    break;
                end
                check_equal("phase", int'(phase), int'(PH_PLAYER_TURN));
            end
        end

        if (best_total(0) > BUST_LIMIT) begin
            check_equal("dealer card count", model_count[1], 1);
        end else begin
            idle_cycles(next_random(5));
            press(BTN_STAND);
            wait_phase(PH_DONE);
            p = best_total(0);
            d = best_total(1);
            if (d <= BUST_LIMIT && d < DEALER_STAND && model_count[1] < HAND_SIZE) begin
                report_failure("dealer stood below its drawing limit");
            end
            if (d > BUST_LIMIT) begin
                expect_res = RES_PLAYER_WIN;
            end else if (p > d) begin
                expect_res = RES_PLAYER_WIN;
            end else if (p < d) begin
                expect_res = RES_DEALER_WIN;
            end else begin
                expect_res = RES_PUSH;
            end
            check_equal("result", int'(result), int'(expect_res));
        end

        // late buttons leave the finished game alone
        base = strobe_count;
        press(BTN_HIT);
        press(BTN_STAND);
        idle_cycles(4);
        @(negedge clk);
        check_equal("phase", int'(phase), int'(PH_DONE));
        check_equal("result", int'(result), int'(expect_res));
        check_equal("strobe count", strobe_count, base);
    endtask

    // ------------------------------
    // main sequence and watchdog
    // ------------------------------
    initial begin : stimulus
        rst          = 1'b1;
        start        = 1'b0;
        deal         = 1'b0;
        hit          = 1'b0;
        stand        = 1'b0;
        strobe_count = 0;
        totals_due   = 1'b0;
        clear_model();
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst = 1'b0;
        @(negedge clk);
        check_equal("phase", int'(phase), int'(PH_IDLE));
        check_equal("result", int'(result), int'(RES_NONE));
        check_equal("player_total", int'(player_total), 0);
        check_equal("dealer_total", int'(dealer_total), 0);
        for (int g = 0; g < NUM_GAMES; g++) begin
            play_game();
        end
        $display("Regression passed");
        $finish;
    end

    initial begin : watchdog
        repeat (RESET_CYCLES + NUM_GAMES * GAME_CYCLES) @(posedge clk);
        report_failure("watchdog expired before all games finished");
    end

endmodule

/* src.f */
verilog/bj_card_pkg.sv
verilog/bj_game_pkg.sv
verilog/hand_if.sv
verilog/card_source.sv
verilog/hand_ledger.sv
verilog/blackjack_fsm.sv
verilog/blackjack_top.sv
dv/blackjack_tb.sv

/* Makefile */
# Verilator flow for the blackjack controller
VERILATOR  ?= verilator
TOP        ?= blackjack_tb
RTL_TOP    ?= blackjack_top
FILELIST   ?= src.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_TEXT  ?= Regression passed
VFLAGS     ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only -Wall

SOURCES    := $(shell cat $(FILELIST))
RTL_FILES  := $(shell grep '^verilog/' $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the simulation log decides pass or fail
run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_FILES)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
